// ==== common/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// core word width in bits
`define DC_DATA_W 32

// words in one cache line
`define DC_WORDS_PER_LINE 4

// number of lines, direct mapped
`define DC_LINES 16

// byte address width
`define DC_ADDR_W 32

`endif

// ==== common/dcache_pkg.sv ====
package dcache_pkg;

`include "dcache_settings.svh"

    localparam int byte_w   = $clog2(`DC_DATA_W / 8);
    localparam int offset_w = $clog2(`DC_WORDS_PER_LINE);
    localparam int index_w  = $clog2(`DC_LINES);
    localparam int tag_w    = `DC_ADDR_W - index_w - offset_w - byte_w;

    typedef logic [`DC_DATA_W-1:0]                     word_t;
    typedef logic [`DC_DATA_W/8-1:0]                   strb_t;
    typedef logic [`DC_ADDR_W-1:0]                     addr_t;
    typedef logic [index_w-1:0]                        index_t;
    typedef logic [offset_w-1:0]                       offset_t;
    typedef logic [tag_w-1:0]                          tag_t;
    typedef logic [`DC_WORDS_PER_LINE*`DC_DATA_W-1:0]  line_t;

    typedef enum logic [2:0] {
        ctrl_idle,
        ctrl_lookup,
        ctrl_respond,
        ctrl_miss_wait,
        ctrl_peri_wait
    } ctrl_state_t;

    typedef enum logic [1:0] {
        mover_idle,
        mover_writeback,
        mover_refill,
        mover_done
    } mover_state_t;

endpackage

// ==== common/wb_pkg.sv ====
package wb_pkg;

`include "dcache_settings.svh"

    // bus addresses words, not bytes
    localparam int wb_adr_w = `DC_ADDR_W - $clog2(`DC_DATA_W / 8);

    typedef logic [wb_adr_w-1:0]        wb_adr_t;
    typedef logic [`DC_DATA_W/8-1:0]    wb_sel_t;
    typedef logic [`DC_DATA_W-1:0]      wb_dat_t;

endpackage

// ==== dcache/dcache_arrays.sv ====
`timescale 1ns/1ps

`include "dcache_settings.svh"

module dcache_arrays
    import dcache_pkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  index_t  rd_index,
    input  logic    st_we,
    input  index_t  st_index,
    input  offset_t st_offset,
    input  word_t   st_data,
    input  strb_t   st_strb,
    input  logic    fill_we,
    input  offset_t fill_offset,
    input  word_t   fill_data,
    input  logic    tag_we,
    input  index_t  tag_index,
    input  tag_t    tag_data,
    input  logic    dirty_set,
    input  logic    dirty_clear,
    output line_t   rd_line,
    output tag_t    rd_tag,
    output logic    rd_valid,
    output logic    rd_dirty
);
    line_t             data_mem [`DC_LINES];
    tag_t              tag_mem  [`DC_LINES];
    logic [`DC_LINES-1:0] valid_bits;
    logic [`DC_LINES-1:0] dirty_bits;

    // refill words land in the line of the pending request
    always_ff @(posedge CLK) begin
        if (st_we) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (st_strb[b]) begin
                    data_mem[st_index][(st_offset * $bits(strb_t) + b) * 8 +: 8] <=
                        st_data[b*8 +: 8];
                end
            end
        end else if (fill_we) begin
            data_mem[st_index][fill_offset * $bits(word_t) +: $bits(word_t)] <= fill_data;
        end
        if (tag_we) begin
            tag_mem[tag_index] <= tag_data;
        end
        rd_line <= data_mem[rd_index];
        // new tag is visible on the read port in the cycle it is written
        rd_tag <= (tag_we && tag_index == rd_index) ? tag_data : tag_mem[rd_index];
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            rd_valid   <= 1'b0;
            rd_dirty   <= 1'b0;
        end else begin
            if (tag_we) begin
                valid_bits[tag_index] <= 1'b1;
            end
            if (dirty_set) begin
                dirty_bits[st_index] <= 1'b1;
            end else if (dirty_clear) begin
                dirty_bits[tag_index] <= 1'b0;
            end
            rd_valid <= (tag_we && tag_index == rd_index) || valid_bits[rd_index];
            rd_dirty <= (dirty_clear && tag_index == rd_index) ? 1'b0 : dirty_bits[rd_index];
        end
    end

endmodule

// ==== dcache/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  logic    req_valid,
    input  logic    req_write,
    input  logic    req_peri,
    input  addr_t   req_addr,
    input  word_t   req_wdata,
    input  strb_t   req_wstrb,
    output logic    req_ready,
    output logic    rsp_valid,
    output word_t   rsp_rdata,
    output index_t  rd_index,
    input  line_t   rd_line,
    input  tag_t    rd_tag,
    input  logic    rd_valid,
    input  logic    rd_dirty,
    output logic    st_we,
    output index_t  st_index,
    output offset_t st_offset,
    output word_t   st_data,
    output strb_t   st_strb,
    output logic    tag_we,
    output index_t  tag_index,
    output tag_t    tag_data,
    output logic    dirty_set,
    output logic    dirty_clear,
    output logic    mv_start,
    output logic    mv_dirty,
    output index_t  mv_index,
    output tag_t    mv_victim_tag,
    output tag_t    mv_new_tag,
    output line_t   mv_victim_line,
    input  logic    mv_done,
    output logic    pp_start,
    output addr_t   pp_addr,
    output logic    pp_write,
    output word_t   pp_wdata,
    output strb_t   pp_wstrb,
    input  logic    pp_done,
    input  word_t   pp_rdata
);
    ctrl_state_t state;
    addr_t       addr_q;
    logic        write_q;
    logic        peri_q;
    word_t       wdata_q;
    strb_t       wstrb_q;
    word_t       rdata_q;
    index_t      idx_q;
    offset_t     off_q;
    tag_t        tag_q;
    logic        hit;
    logic        lookup_hit;

    assign idx_q = addr_q[byte_w + offset_w +: index_w];
    assign off_q = addr_q[byte_w +: offset_w];
    assign tag_q = addr_q[byte_w + offset_w + index_w +: tag_w];

    assign hit        = rd_valid && (rd_tag == tag_q);
    assign lookup_hit = (state == ctrl_lookup) && !peri_q && hit;

    assign req_ready = (state == ctrl_idle);
    assign rsp_valid = (state == ctrl_respond);
    assign rsp_rdata = rdata_q;

    // idle reads the incoming index so lookup has the line one cycle later
    assign rd_index = (state == ctrl_idle) ? req_addr[byte_w + offset_w +: index_w] : idx_q;

    // store hit, byte merge happens in the data array
    assign st_we     = lookup_hit && write_q;
    assign st_index  = idx_q;
    assign st_offset = off_q;
    assign st_data   = wdata_q;
    assign st_strb   = wstrb_q;
    assign dirty_set = st_we;

    // refill finished
    assign tag_we      = (state == ctrl_miss_wait) && mv_done;
    assign tag_index   = idx_q;
    assign tag_data    = tag_q;
    assign dirty_clear = tag_we;

    assign mv_start       = (state == ctrl_lookup) && !peri_q && !hit;
    assign mv_dirty       = rd_valid && rd_dirty;
    assign mv_index       = idx_q;
    assign mv_victim_tag  = rd_tag;
    assign mv_new_tag     = tag_q;
    assign mv_victim_line = rd_line;

    assign pp_start = (state == ctrl_lookup) && peri_q;
    assign pp_addr  = addr_q;
    assign pp_write = write_q;
    assign pp_wdata = wdata_q;
    assign pp_wstrb = wstrb_q;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= ctrl_idle;
        end else begin
            case (state)
                ctrl_idle: begin
                    if (req_valid) begin
                        state <= ctrl_lookup;
                    end
                end
                ctrl_lookup: begin
                    if (peri_q) begin
                        state <= ctrl_peri_wait;
                    end else if (hit) begin
                        state <= ctrl_respond;
                    end else begin
                        state <= ctrl_miss_wait;
                    end
                end
                ctrl_respond: state <= ctrl_idle;
                // retry the lookup once the line is in place
                ctrl_miss_wait: begin
                    if (mv_done) begin
                        state <= ctrl_lookup;
                    end
                end
                ctrl_peri_wait: begin
                    if (pp_done) begin
                        state <= ctrl_respond;
                    end
                end
                default: state <= ctrl_idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (req_valid && req_ready) begin
            addr_q  <= req_addr;
            write_q <= req_write;
            peri_q  <= req_peri;
            wdata_q <= req_wdata;
            wstrb_q <= req_wstrb;
        end
        if (lookup_hit && !write_q) begin
            rdata_q <= rd_line[off_q * $bits(word_t) +: $bits(word_t)];
        end else if (state == ctrl_peri_wait && pp_done) begin
            rdata_q <= pp_rdata;
        end
    end

endmodule

// ==== dcache/line_mover.sv ====
`timescale 1ns/1ps

module line_mover
    import dcache_pkg::*;
    import wb_pkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  logic    mv_start,
    input  logic    mv_dirty,
    input  index_t  mv_index,
    input  tag_t    mv_victim_tag,
    input  tag_t    mv_new_tag,
    input  line_t   mv_victim_line,
    output logic    mv_done,
    output logic    fill_we,
    output offset_t fill_offset,
    output word_t   fill_data,
    output logic    mv_cyc,
    output logic    mv_stb,
    output logic    mv_we,
    output wb_adr_t mv_adr,
    output wb_dat_t mv_dat_w,
    output wb_sel_t mv_sel,
    input  logic    mv_ack,
    input  wb_dat_t mv_dat_r
);
    mover_state_t state;
    index_t       index_q;
    tag_t         victim_q;
    tag_t         new_q;
    line_t        line_q;
    offset_t      beat;
    logic         beat_ack;

    assign beat_ack = mv_stb && mv_ack;

    // cyc stays up from the first writeback beat to the last refill beat
    assign mv_cyc   = (state == mover_writeback) || (state == mover_refill);
    assign mv_we    = (state == mover_writeback);
    assign mv_adr   = {mv_we ? victim_q : new_q, index_q, beat};
    assign mv_dat_w = line_q[beat * $bits(wb_dat_t) +: $bits(wb_dat_t)];
    assign mv_sel   = '1;

    assign fill_we     = (state == mover_refill) && beat_ack;
    assign fill_offset = beat;
    assign fill_data   = mv_dat_r;
    assign mv_done     = (state == mover_done);

    always_ff @(posedge CLK) begin
        if (RST) begin
            state  <= mover_idle;
            mv_stb <= 1'b0;
            beat   <= '0;
        end else begin
            case (state)
                mover_idle: begin
                    if (mv_start) begin
                        state  <= mv_dirty ? mover_writeback : mover_refill;
                        mv_stb <= 1'b1;
                        beat   <= '0;
                    end
                end
                mover_writeback, mover_refill: begin
                    if (beat_ack) begin
                        // stb drops for one cycle after every ack
                        mv_stb <= 1'b0;
                        beat   <= beat + 1'b1;
                        if (beat == '1) begin
                            state <= (state == mover_writeback) ? mover_refill : mover_done;
                        end
                    end else if (!mv_stb) begin
                        mv_stb <= 1'b1;
                    end
                end
                mover_done: state <= mover_idle;
                default: state <= mover_idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == mover_idle && mv_start) begin
            index_q  <= mv_index;
            victim_q <= mv_victim_tag;
            new_q    <= mv_new_tag;
            line_q   <= mv_victim_line;
        end
    end

endmodule

// ==== hw/peri_port.sv ====
`timescale 1ns/1ps

module peri_port
    import dcache_pkg::*;
    import wb_pkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  logic    pp_start,
    input  addr_t   pp_addr,
    input  logic    pp_write,
    input  word_t   pp_wdata,
    input  strb_t   pp_wstrb,
    output logic    pp_done,
    output word_t   pp_rdata,
    output logic    pp_cyc,
    output logic    pp_stb,
    output logic    pp_we,
    output wb_adr_t pp_adr,
    output wb_dat_t pp_dat_w,
    output wb_sel_t pp_sel,
    input  logic    pp_ack,
    input  wb_dat_t pp_dat_r
);
    logic  busy;
    addr_t addr_q;
    logic  write_q;
    word_t wdata_q;
    strb_t wstrb_q;

    // single transfer, so cyc and stb fall together on ack
    assign pp_cyc   = busy;
    assign pp_stb   = busy;
    assign pp_we    = write_q;
    assign pp_adr   = addr_q[$bits(addr_t)-1:byte_w];
    assign pp_dat_w = wdata_q;
    assign pp_sel   = wstrb_q;

    always_ff @(posedge CLK) begin
        if (RST) begin
            busy    <= 1'b0;
            pp_done <= 1'b0;
        end else begin
            pp_done <= busy && pp_ack;
            if (pp_start) begin
                busy <= 1'b1;
            end else if (pp_ack) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (pp_start) begin
            addr_q  <= pp_addr;
            write_q <= pp_write;
            wdata_q <= pp_wdata;
            wstrb_q <= pp_wstrb;
        end
        if (busy && pp_ack) begin
            pp_rdata <= pp_dat_r;
        end
    end

endmodule

// ==== hw/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter
    import wb_pkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  logic    mv_cyc,
    input  logic    mv_stb,
    input  logic    mv_we,
    input  wb_adr_t mv_adr,
    input  wb_dat_t mv_dat_w,
    input  wb_sel_t mv_sel,
    output logic    mv_ack,
    output wb_dat_t mv_dat_r,
    input  logic    pp_cyc,
    input  logic    pp_stb,
    input  logic    pp_we,
    input  wb_adr_t pp_adr,
    input  wb_dat_t pp_dat_w,
    input  wb_sel_t pp_sel,
    output logic    pp_ack,
    output wb_dat_t pp_dat_r,
    output logic    bus_cyc,
    output logic    bus_stb,
    output logic    bus_we,
    output wb_adr_t bus_adr,
    output wb_dat_t bus_dat_w,
    output wb_sel_t bus_sel,
    input  logic    bus_ack,
    input  wb_dat_t bus_dat_r
);
    logic locked;
    logic lock_pp;
    logic gnt_mv;
    logic gnt_pp;

    // free bus goes to the mover first
    assign gnt_mv = locked ? !lock_pp : mv_cyc;
    assign gnt_pp = locked ? lock_pp : (pp_cyc && !mv_cyc);

    assign bus_cyc   = (gnt_mv && mv_cyc) || (gnt_pp && pp_cyc);
    assign bus_stb   = (gnt_mv && mv_stb) || (gnt_pp && pp_stb);
    assign bus_we    = gnt_pp ? pp_we : mv_we;
    assign bus_adr   = gnt_pp ? pp_adr : mv_adr;
    assign bus_dat_w = gnt_pp ? pp_dat_w : mv_dat_w;
    assign bus_sel   = gnt_pp ? pp_sel : mv_sel;

    assign mv_ack   = gnt_mv && bus_ack;
    assign pp_ack   = gnt_pp && bus_ack;
    assign mv_dat_r = gnt_mv ? bus_dat_r : '0;
    assign pp_dat_r = gnt_pp ? bus_dat_r : '0;

    always_ff @(posedge CLK) begin
        if (RST) begin
            locked  <= 1'b0;
            lock_pp <= 1'b0;
        end else if (!locked) begin
            if (mv_cyc || pp_cyc) begin
                locked  <= 1'b1;
                lock_pp <= !mv_cyc;
            end
        end else if (lock_pp ? !pp_cyc : !mv_cyc) begin
            // owner released cyc
            locked <= 1'b0;
        end
    end

endmodule

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
    import wb_pkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  logic    req_valid,
    input  logic    req_write,
    input  logic    req_peri,
    input  addr_t   req_addr,
    input  word_t   req_wdata,
    input  strb_t   req_wstrb,
    output logic    req_ready,
    output logic    rsp_valid,
    output word_t   rsp_rdata,
    output logic    bus_cyc,
    output logic    bus_stb,
    output logic    bus_we,
    output wb_adr_t bus_adr,
    output wb_dat_t bus_dat_w,
    output wb_sel_t bus_sel,
    input  wb_dat_t bus_dat_r,
    input  logic    bus_ack
);
    index_t  rd_index;
    line_t   rd_line;
    tag_t    rd_tag;
    logic    rd_valid;
    logic    rd_dirty;
    logic    st_we;
    index_t  st_index;
    offset_t st_offset;
    word_t   st_data;
    strb_t   st_strb;
    logic    fill_we;
    offset_t fill_offset;
    word_t   fill_data;
    logic    tag_we;
    index_t  tag_index;
    tag_t    tag_data;
    logic    dirty_set;
    logic    dirty_clear;

    logic    mv_start;
    logic    mv_dirty;
    index_t  mv_index;
    tag_t    mv_victim_tag;
    tag_t    mv_new_tag;
    line_t   mv_victim_line;
    logic    mv_done;
    logic    mv_cyc;
    logic    mv_stb;
    logic    mv_we;
    wb_adr_t mv_adr;
    wb_dat_t mv_dat_w;
    wb_sel_t mv_sel;
    logic    mv_ack;
    wb_dat_t mv_dat_r;

    logic    pp_start;
    addr_t   pp_addr;
    logic    pp_write;
    word_t   pp_wdata;
    strb_t   pp_wstrb;
    logic    pp_done;
    word_t   pp_rdata;
    logic    pp_cyc;
    logic    pp_stb;
    logic    pp_we;
    wb_adr_t pp_adr;
    wb_dat_t pp_dat_w;
    wb_sel_t pp_sel;
    logic    pp_ack;
    wb_dat_t pp_dat_r;

    dcache_ctrl dcache_ctrl_inst (.*);

    dcache_arrays dcache_arrays_inst (.*);

    line_mover line_mover_inst (.*);

    peri_port peri_port_inst (.*);

    wb_arbiter wb_arbiter_inst (.*);

endmodule

// ==== bench/wb_slave_model.sv ====
`timescale 1ns/1ps

module wb_slave_model
    import wb_pkg::*;
#(
    parameter wb_dat_t fill_key = 32'h0
) (
    input  logic    CLK,
    input  logic    RST,
    input  logic    cyc,
    input  logic    stb,
    input  logic    we,
    input  wb_adr_t adr,
    input  wb_dat_t dat_w,
    input  wb_sel_t sel,
    output wb_dat_t dat_r,
    output logic    ack
);
    wb_dat_t     mem [4096];
    int          seed = 87;
    logic [31:0] rnd;
    logic [1:0]  wait_cnt;

    always @(posedge CLK) begin
        if (RST) begin
            ack      <= 1'b0;
            wait_cnt <= 2'd0;
            // fill pattern from the word address
            for (int i = 0; i < 4096; i++) begin
                mem[i] <= wb_dat_t'(i) ^ fill_key;
            end
        end else if (ack) begin
            ack <= 1'b0;
        end else if (cyc && stb) begin
            if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                if (we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (sel[b]) begin
                            mem[adr[11:0]][b*8 +: 8] <= dat_w[b*8 +: 8];
                        end
                    end
                end
                dat_r <= mem[adr[11:0]];
                ack   <= 1'b1;
                // wait states for the next transfer
                rnd      = $random(seed);
                wait_cnt <= rnd[1:0];
            end
        end
    end

endmodule

// ==== bench/dcache_sva.sv ====
`timescale 1ns/1ps

module dcache_sva (
    input logic CLK,
    input logic RST,
    input logic req_valid,
    input logic req_ready,
    input logic req_peri,
    input logic rsp_valid,
    input logic bus_cyc,
    input logic bus_stb
);
    int unsigned fail_count = 0;

    stb_inside_cyc: assert property (@(posedge CLK) disable iff (RST)
        bus_stb |-> bus_cyc)
    else begin
        $error("bus stb high without cyc");
        fail_count++;
    end

    rsp_single_cycle: assert property (@(posedge CLK) disable iff (RST)
        rsp_valid |=> !rsp_valid)
    else begin
        $error("rsp_valid held longer than one cycle");
        fail_count++;
    end

    ready_low_on_bus: assert property (@(posedge CLK) disable iff (RST)
        bus_cyc |-> !req_ready)
    else begin
        $error("req_ready high during a bus cycle");
        fail_count++;
    end

    // cached request that stays off the bus is a hit
    hit_two_cycles: assert property (@(posedge CLK) disable iff (RST)
        $past(req_valid && req_ready && !req_peri, 2) && !bus_cyc |-> rsp_valid)
    else begin
        $error("hit did not answer in two cycles");
        fail_count++;
    end

endmodule

bind dcache_top dcache_sva dcache_sva_inst (
    .CLK       (CLK),
    .RST       (RST),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_peri  (req_peri),
    .rsp_valid (rsp_valid),
    .bus_cyc   (bus_cyc),
    .bus_stb   (bus_stb)
);

// ==== bench/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
    import wb_pkg::*;
();
    localparam int    clk_period = 4;
    localparam int    total_ops  = 210;
    localparam word_t fill_key   = 32'hc0de_5a00;

    logic    CLK;
    logic    RST;
    logic    req_valid;
    logic    req_write;
    logic    req_peri;
    addr_t   req_addr;
    word_t   req_wdata;
    strb_t   req_wstrb;
    logic    req_ready;
    logic    rsp_valid;
    word_t   rsp_rdata;
    logic    bus_cyc;
    logic    bus_stb;
    logic    bus_we;
    wb_adr_t bus_adr;
    wb_dat_t bus_dat_w;
    wb_sel_t bus_sel;
    wb_dat_t bus_dat_r;
    logic    bus_ack;

    word_t       shadow [4096];
    int          seed = 87;
    int unsigned cyc_rises;
    logic        cyc_prev;

    dcache_top dcache_top_inst (.*);

    wb_slave_model #(.fill_key(fill_key)) wb_slave_model_inst (
        .CLK   (CLK),
        .RST   (RST),
        .cyc   (bus_cyc),
        .stb   (bus_stb),
        .we    (bus_we),
        .adr   (bus_adr),
        .dat_w (bus_dat_w),
        .sel   (bus_sel),
        .dat_r (bus_dat_r),
        .ack   (bus_ack)
    );

    initial begin
        CLK = 1'b0;
        forever #(clk_period / 2) CLK = ~CLK;
    end

    // counts bus cycles started by any master
    always @(posedge CLK) begin
        if (RST) begin
            cyc_rises <= 0;
            cyc_prev  <= 1'b0;
        end else begin
            cyc_prev <= bus_cyc;
            if (bus_cyc && !cyc_prev) begin
                cyc_rises <= cyc_rises + 1;
            end
        end
    end

    initial begin
        #(total_ops * 60 * clk_period);
        $display("timeout: a request did not complete within the time limit");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic check_equal(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("[FAIL] time %0t: %s: got %h, expected %h", $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input strb_t strb);
        word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // one request, cycles counted from the accepting edge to rsp_valid
    task automatic do_access(input logic write, input logic peri, input addr_t addr,
                             input word_t data, input strb_t strb,
                             output word_t rdata, output int cycles);
        @(negedge CLK);
        req_valid = 1'b1;
        req_write = write;
        req_peri  = peri;
        req_addr  = addr;
        req_wdata = data;
        req_wstrb = strb;
        while (!req_ready) @(negedge CLK);
        @(negedge CLK);
        req_valid = 1'b0;
        cycles = 1;
        while (!rsp_valid) begin
            @(negedge CLK);
            cycles++;
        end
        rdata = rsp_rdata;
    endtask

    task automatic load_check(input addr_t addr, input logic peri, input string what,
                              output word_t data, output int cycles);
        do_access(1'b0, peri, addr, '0, '0, data, cycles);
        check_equal(data, shadow[addr[13:2]], what);
    endtask

    task automatic store_word(input addr_t addr, input word_t data, input strb_t strb,
                              input logic peri);
        word_t unused;
        int    cycles;
        shadow[addr[13:2]] = merge_bytes(shadow[addr[13:2]], data, strb);
        do_access(1'b1, peri, addr, data, strb, unused, cycles);
    endtask

    task automatic test_fresh_line();
        word_t       data;
        int          cycles;
        int unsigned rises;
        load_check(32'h0000_0040, 1'b0, "fresh line load", data, cycles);
        rises = cyc_rises;
        load_check(32'h0000_0044, 1'b0, "same line load", data, cycles);
        check_equal(word_t'(cycles), 32'd2, "hit latency in cycles");
        check_equal(word_t'(cyc_rises - rises), 32'd0, "bus cycles during hit");
    endtask

    task automatic test_partial_store();
        word_t data;
        int    cycles;
        store_word(32'h0000_0088, 32'haabb_ccdd, 4'b0101, 1'b0);
        load_check(32'h0000_0088, 1'b0, "load after partial store", data, cycles);
    endtask

    task automatic test_dirty_evict();
        word_t data;
        int    cycles;
        store_word(32'h0000_00c4, 32'h1234_5678, 4'hf, 1'b0);
        // same index, next tag
        load_check(32'h0000_01c4, 1'b0, "conflicting line load", data, cycles);
        check_equal(wb_slave_model_inst.mem[12'h031], 32'h1234_5678, "victim in memory");
        load_check(32'h0000_00c4, 1'b0, "reload of evicted line", data, cycles);
        check_equal(data, 32'h1234_5678, "evicted store value");
    endtask

    task automatic test_peripheral();
        word_t       data;
        int          cycles;
        int unsigned rises;
        rises = cyc_rises;
        store_word(32'h0000_3000, 32'hcafe_f00d, 4'hf, 1'b1);
        check_equal(word_t'(cyc_rises - rises), 32'd1, "bus cycles for peripheral write");
        load_check(32'h0000_3000, 1'b1, "peripheral read", data, cycles);
        check_equal(word_t'(cyc_rises - rises), 32'd2, "bus cycles for peripheral read");
        load_check(32'h0000_3000, 1'b1, "repeated peripheral read", data, cycles);
        check_equal(word_t'(cyc_rises - rises), 32'd3, "bus cycles for repeated read");
    endtask

    task automatic test_random_mix();
        logic [31:0] rnd;
        word_t       wdata;
        word_t       data;
        addr_t       addr;
        int          cycles;
        for (int i = 0; i < 200; i++) begin
            rnd   = $random(seed);
            wdata = $random(seed);
            // four tags over the same sixteen indices
            addr = 32'h0000_1000 | {22'd0, rnd[1:0], rnd[5:2], rnd[7:6], 2'b00};
            if (rnd[8]) begin
                store_word(addr, wdata, rnd[12:9], 1'b0);
            end else begin
                load_check(addr, 1'b0, "random load", data, cycles);
            end
        end
    endtask

    initial begin
        RST       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_peri  = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = word_t'(i) ^ fill_key;
        end
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;

        test_fresh_line();
        test_partial_store();
        test_dirty_evict();
        test_peripheral();
        test_random_mix();

        repeat (2) @(negedge CLK);
        if (dcache_top_inst.dcache_sva_inst.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("assertion failures: %0d", dcache_top_inst.dcache_sva_inst.fail_count);
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+common
common/dcache_pkg.sv
common/wb_pkg.sv
dcache/dcache_arrays.sv
dcache/dcache_ctrl.sv
dcache/line_mover.sv
hw/peri_port.sv
hw/wb_arbiter.sv
hw/dcache_top.sv
bench/wb_slave_model.sv
bench/dcache_sva.sv
bench/tb_dcache.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_dcache -o tb_dcache
	./obj_dir/tb_dcache +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
